//--- build.f
source/ctrlPkg.sv
source/fetchArbiter.sv
source/instrSlot.sv
source/ctrlMerge.sv
source/pipeControl.sv
testbench/pipeControl_assertions.sv
testbench/pipeControl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the pipeControl testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module pipeControl_tb -f build.f -o pipeControl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pipeControl_sim +verilator+error+limit+100 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -qx "Everything OK" "$LOG"; then
    echo "simulation passed (exit status $simStatus)"
    exit 0
else
    echo "simulation failed (exit status $simStatus)"
    exit 1
fi

//--- source/ctrlMerge.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlMerge #(
    parameter int NumSlots = 5
) (
    input  wire                                    fetchGrant,
    input  wire ctrlPkg::slotCtrl_t [NumSlots-1:0] slotCtrl,
    output ctrlPkg::pipeCtrl_t                     ctrl
);

    logic jumpAny;

    //////////////////////////////
    // merge slot controls
    //////////////////////////////
    always_comb
    begin
        ctrl    = '0;
        jumpAny = 1'b0;
        for (int s = 0; s < NumSlots; s++)
        begin
            jumpAny       |= slotCtrl[s].jump;
            ctrl.iorD     |= slotCtrl[s].memAccess;
            ctrl.memWrite |= slotCtrl[s].memWrite;
            ctrl.memToReg |= slotCtrl[s].memToReg;
            ctrl.regWrite |= slotCtrl[s].regWrite;
            // only one slot writes back in a cycle
            if (slotCtrl[s].regWrite)
                ctrl.destAddr = slotCtrl[s].destAddr;
        end

        // fetch and jump never share a cycle
        ctrl.pcWrite = fetchGrant || jumpAny;
        ctrl.pcSrc   = jumpAny ? ctrlPkg::PcJump : ctrlPkg::PcSeq;
        ctrl.irWrite = fetchGrant;
    end

endmodule

`default_nettype wire

//--- source/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    //////////////////////////////
    // opcodes
    //////////////////////////////
    localparam logic [5:0] OpR    = 6'h00;
    localparam logic [5:0] OpJ    = 6'h02;
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpLw   = 6'h23;
    localparam logic [5:0] OpSw   = 6'h2b;

    typedef logic [4:0] regAddr_t;

    //////////////////////////////
    // instruction word views
    //////////////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_t;

    // j shares the opcode bits of this view
    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
    } iType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
    } instrWord_t;

    typedef enum logic [2:0] {
        SlotIdle,
        SlotDecode,
        SlotExecute,
        SlotMemRead,
        SlotMemWrite,
        SlotPass,
        SlotWriteBack,
        SlotJump
    } slotState_t;

    typedef enum logic {
        PcSeq,
        PcJump
    } pcSrc_t;

    // slot -> arbiter
    typedef struct packed {
        logic fetchReq;
        logic decodingJump;    // next state is SlotJump
        logic memBusy;
        logic started;         // sticky after first fetch
    } slotStatus_t;

    // slot -> merger
    typedef struct packed {
        logic     jump;
        logic     memAccess;
        logic     memWrite;
        logic     regWrite;
        logic     memToReg;
        regAddr_t destAddr;
    } slotCtrl_t;

    // datapath controls
    typedef struct packed {
        logic     pcWrite;
        pcSrc_t   pcSrc;
        logic     irWrite;
        logic     iorD;
        logic     memWrite;
        logic     memToReg;
        logic     regWrite;
        regAddr_t destAddr;
    } pipeCtrl_t;

endpackage

`default_nettype wire

//--- source/fetchArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fetchArbiter #(
    parameter int NumSlots = 5,
    parameter int JumpHold = 2
) (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire ctrlPkg::slotStatus_t [NumSlots-1:0] status,
    output logic [NumSlots-1:0]                    grant,
    output logic [NumSlots-1:0]                    slotEnable,
    output logic                                   fetchGrant
);

    localparam int HoldW = (JumpHold > 0) ? $clog2(JumpHold + 1) : 1;

    logic             startReg;
    logic             anyMemBusy;
    logic             anyDecodingJump;
    logic             jumpActive;    // some slot sits in SlotJump
    logic [HoldW-1:0] holdCnt;
    logic             fetchOk;
    logic             found;

    //////////////////////////////
    // staggered start
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            startReg <= 1'b0;
        else
            startReg <= 1'b1;
    end

    // each slot wakes once the one before it has fetched
    always_comb
    begin
        slotEnable[0] = startReg;
        for (int k = 1; k < NumSlots; k++)
            slotEnable[k] = status[k-1].started;
    end

    //////////////////////////////
    // blocking conditions
    //////////////////////////////
    always_comb
    begin
        anyMemBusy      = 1'b0;
        anyDecodingJump = 1'b0;
        for (int s = 0; s < NumSlots; s++)
        begin
            anyMemBusy      |= status[s].memBusy;
            anyDecodingJump |= status[s].decodingJump;
        end
    end

    // jump window: decode, SlotJump, then JumpHold more cycles
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            jumpActive <= 1'b0;
            holdCnt    <= '0;
        end
        else
        begin
            jumpActive <= anyDecodingJump;
            if (jumpActive)
                holdCnt <= HoldW'(JumpHold);
            else if (holdCnt != '0)
                holdCnt <= holdCnt - 1'b1;
        end
    end

    assign fetchOk = !anyMemBusy && !anyDecodingJump && !jumpActive && (holdCnt == '0);

    // lowest index wins
    always_comb
    begin
        grant = '0;
        found = 1'b0;
        for (int s = 0; s < NumSlots; s++)
        begin
            if (fetchOk && status[s].fetchReq && !found)
            begin
                grant[s] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    assign fetchGrant = found;

endmodule

`default_nettype wire

//--- source/instrSlot.sv
`timescale 1ns/1ps
`default_nettype none

module instrSlot #(
    parameter int NumSlots = 5
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        enable,
    input  wire                        grant,
    input  wire ctrlPkg::instrWord_t   instruction,
    output ctrlPkg::slotStatus_t       status,
    output ctrlPkg::slotCtrl_t         slotCtrl
);

    // five-cycle instructions need five slots to keep fetch going
    if (NumSlots < 5)
    begin : gSlotCountCheck
        $error("instrSlot needs NumSlots of at least 5");
    end

    ctrlPkg::slotState_t state;
    ctrlPkg::slotState_t nextState;
    ctrlPkg::instrWord_t instrReg;    // word latched at grant
    ctrlPkg::regAddr_t   destAddr;
    logic [5:0]          opcode;
    logic                started;
    logic                isLw;
    logic                isSw;
    logic                writesBack;

    //////////////////////////////
    // decode through the union
    //////////////////////////////
    assign opcode     = instrReg.r.opcode;
    assign isLw       = (opcode == ctrlPkg::OpLw);
    assign isSw       = (opcode == ctrlPkg::OpSw);
    assign writesBack = (opcode == ctrlPkg::OpR) || (opcode == ctrlPkg::OpAddi);
    assign destAddr   = (opcode == ctrlPkg::OpR) ? instrReg.r.rd : instrReg.i.rt;

    always_ff @(posedge clk)
    begin
        if (grant)
            instrReg <= instruction;
    end

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_comb
    begin
        nextState = state;
        case (state)
            ctrlPkg::SlotIdle:
                if (grant)
                    nextState = ctrlPkg::SlotDecode;
            ctrlPkg::SlotDecode:
                if (opcode == ctrlPkg::OpJ)
                    nextState = ctrlPkg::SlotJump;
                else
                    nextState = ctrlPkg::SlotExecute;
            ctrlPkg::SlotExecute:
            begin
                if (isLw)
                    nextState = ctrlPkg::SlotMemRead;
                else if (isSw)
                    nextState = ctrlPkg::SlotMemWrite;
                else
                    nextState = ctrlPkg::SlotPass;
            end
            ctrlPkg::SlotMemRead:
                nextState = ctrlPkg::SlotWriteBack;
            ctrlPkg::SlotMemWrite:
                nextState = ctrlPkg::SlotIdle;    // sw ends here
            ctrlPkg::SlotPass:
                nextState = writesBack ? ctrlPkg::SlotWriteBack : ctrlPkg::SlotIdle;
            ctrlPkg::SlotWriteBack:
                nextState = ctrlPkg::SlotIdle;
            ctrlPkg::SlotJump:
                nextState = ctrlPkg::SlotIdle;
            default:
                nextState = ctrlPkg::SlotIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= ctrlPkg::SlotIdle;
            started <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (grant)
                started <= 1'b1;
        end
    end

    //////////////////////////////
    // outputs from state
    //////////////////////////////
    assign status.fetchReq     = enable && (state == ctrlPkg::SlotIdle);
    // next state is SlotJump, without going through the grant path
    assign status.decodingJump = (state == ctrlPkg::SlotDecode) && (opcode == ctrlPkg::OpJ);
    assign status.memBusy      = (state == ctrlPkg::SlotMemRead) ||
                                 (state == ctrlPkg::SlotMemWrite);
    assign status.started      = started;

    assign slotCtrl.jump      = (state == ctrlPkg::SlotJump);
    assign slotCtrl.memAccess = status.memBusy;
    assign slotCtrl.memWrite  = (state == ctrlPkg::SlotMemWrite);
    assign slotCtrl.regWrite  = (state == ctrlPkg::SlotWriteBack);
    assign slotCtrl.memToReg  = (state == ctrlPkg::SlotWriteBack) && isLw;
    assign slotCtrl.destAddr  = destAddr;    // merger picks the writing slot

endmodule

`default_nettype wire

//--- source/pipeControl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeControl #(
    parameter int NumSlots = 5,
    parameter int JumpHold = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire ctrlPkg::instrWord_t instruction,
    output ctrlPkg::pipeCtrl_t       ctrl
);

    ctrlPkg::slotStatus_t [NumSlots-1:0] status;
    ctrlPkg::slotCtrl_t   [NumSlots-1:0] slotCtrl;
    logic [NumSlots-1:0]                 grant;
    logic [NumSlots-1:0]                 slotEnable;
    logic                                fetchGrant;

    fetchArbiter #(
        .NumSlots (NumSlots),
        .JumpHold (JumpHold)
    ) uArbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .status     (status),
        .grant      (grant),
        .slotEnable (slotEnable),
        .fetchGrant (fetchGrant)
    );

    //////////////////////////////
    // instruction slots
    //////////////////////////////
    for (genvar s = 0; s < NumSlots; s++)
    begin : gSlot
        instrSlot #(
            .NumSlots (NumSlots)
        ) uSlot (
            .clk         (clk),
            .rst_n       (rst_n),
            .enable      (slotEnable[s]),
            .grant       (grant[s]),
            .instruction (instruction),
            .status      (status[s]),
            .slotCtrl    (slotCtrl[s])
        );
    end

    ctrlMerge #(
        .NumSlots (NumSlots)
    ) uMerge (
        .fetchGrant (fetchGrant),
        .slotCtrl   (slotCtrl),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

//--- testbench/pipeControl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pipeControl_assertions #(
    parameter int JumpHold = 2
) (
    input wire                      clk,
    input wire                      rst_n,
    input wire ctrlPkg::instrWord_t instruction,
    input wire ctrlPkg::pipeCtrl_t  ctrl
);

    int unsigned       failCount = 0;    // polled by the testbench
    logic [5:0]        op;
    logic              fetch;
    logic              fetchJ;
    logic              fetchLw;
    logic              fetchSw;
    logic              fetchWb;
    ctrlPkg::regAddr_t dest;

    //////////////////////////////
    // fetch decode from raw bits
    //////////////////////////////
    assign op      = instruction[31:26];
    assign fetch   = ctrl.pcWrite && (ctrl.pcSrc == ctrlPkg::PcSeq);
    assign fetchJ  = fetch && (op == ctrlPkg::OpJ);
    assign fetchLw = fetch && (op == ctrlPkg::OpLw);
    assign fetchSw = fetch && (op == ctrlPkg::OpSw);
    assign fetchWb = fetch && ((op == ctrlPkg::OpR) || (op == ctrlPkg::OpAddi) || fetchLw);
    assign dest    = (op == ctrlPkg::OpR) ? instruction[15:11] : instruction[20:16];

    // quiet through reset and the first cycle after it
    assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> (ctrl == '0))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl = %h, expected 000 around reset", ctrl);
    end

    // a fetch writes PC and IR together, never beside a memory access
    assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.irWrite || fetch) |-> (fetch && ctrl.irWrite && !ctrl.iorD))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.irWrite = %h ctrl.pcWrite = %h ctrl.pcSrc = %h ctrl.iorD = %h",
               ctrl.irWrite, ctrl.pcWrite, ctrl.pcSrc, ctrl.iorD);
    end

    //////////////////////////////
    // memory stage of lw and sw
    //////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(fetchLw || fetchSw, 3) |-> (ctrl.iorD && (ctrl.memWrite == $past(fetchSw, 3))))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.iorD = %h ctrl.memWrite = %h", ctrl.iorD, ctrl.memWrite);
    end

    assert property (@(posedge clk) disable iff (!rst_n) ctrl.memWrite |-> ctrl.iorD)
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.memWrite = %h with ctrl.iorD = %h", ctrl.memWrite, ctrl.iorD);
    end

    //////////////////////////////
    // writeback
    //////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(fetchWb, 4) |-> (ctrl.regWrite && (ctrl.destAddr == $past(dest, 4)) &&
                               (ctrl.memToReg == $past(fetchLw, 4))))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.regWrite = %h ctrl.destAddr = %h expected %h ctrl.memToReg = %h",
               ctrl.regWrite, ctrl.destAddr, $past(dest, 4), ctrl.memToReg);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.regWrite || ctrl.memToReg) |-> $past(fetchWb, 4))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.regWrite = %h ctrl.memToReg = %h with no matching fetch",
               ctrl.regWrite, ctrl.memToReg);
    end

    //////////////////////////////
    // jump and its hold window
    //////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(fetchJ, 2) |-> (ctrl.pcWrite && (ctrl.pcSrc == ctrlPkg::PcJump)))
    else
    begin
        failCount++;
        $error("CHECK FAILED ctrl.pcWrite = %h ctrl.pcSrc = %h for jump", ctrl.pcWrite, ctrl.pcSrc);
    end

    for (genvar k = 1; k <= JumpHold + 2; k++)
    begin : gJumpGap
        assert property (@(posedge clk) disable iff (!rst_n) $past(fetchJ, k) |-> !fetch)
        else
        begin
            failCount++;
            $error("CHECK FAILED ctrl.irWrite = %h at %0d cycles after a jump fetch",
                   ctrl.irWrite, k);
        end
    end

endmodule

`default_nettype wire

//--- testbench/pipeControl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeControl_tb;

    localparam int Seed         = 9023;
    localparam int Period       = 8;
    localparam int ResetCycles  = 3;
    localparam int TestCycles   = 400;
    localparam int WatchdogTime = 2 * (ResetCycles + TestCycles) * Period;

    logic                clk;
    logic                rst_n;
    ctrlPkg::instrWord_t instruction;
    ctrlPkg::pipeCtrl_t  ctrl;
    integer              randState;

    pipeControl UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    bind pipeControl pipeControl_assertions #(
        .JumpHold (JumpHold)
    ) uChecks (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // one of the five kinds with random register fields
    task automatic driveRandomInstr();
        logic [31:0] word;
        int          kind;
        word = $random(randState);
        kind = $unsigned($random(randState)) % 5;
        case (kind)
            0:       word[31:26] = ctrlPkg::OpR;
            1:       word[31:26] = ctrlPkg::OpAddi;
            2:       word[31:26] = ctrlPkg::OpLw;
            3:       word[31:26] = ctrlPkg::OpSw;
            default: word[31:26] = ctrlPkg::OpJ;
        endcase
        instruction = word;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        randState   = Seed;
        rst_n       = 1'b0;
        instruction = '0;
        repeat (ResetCycles) @(negedge clk);
        rst_n = 1'b1;
        repeat (TestCycles)
        begin
            @(negedge clk);
            driveRandomInstr();
        end
        if (UUT.uChecks.failCount != 0)
        begin
            $display("Something failed");
            $fatal(1, "%0d assertion failures", UUT.uChecks.failCount);
        end
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

    // stop at the first assertion failure
    always @(negedge clk)
    begin
        if (UUT.uChecks.failCount != 0)
        begin
            $display("Something failed");
            $fatal(1, "an assertion failed, run stopped");
        end
    end

    initial
    begin
        #(WatchdogTime);
        $display("Something failed");
        $fatal(1, "watchdog expired before the test finished");
    end

endmodule

`default_nettype wire
